//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_issue
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } index($$0, "** PASS **") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+src
src/iq_pkg.sv
src/iq_interfaces.sv
src/dispatch_stage.sv
src/issue_queue.sv
src/exec_unit.sv
src/ooo_issue_top.sv
verification/tb_ooo_issue.sv

//--- src/dispatch_stage.sv
`timescale 1ns/100ps

`include "iq_macros.svh"

module dispatch_stage import iq_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    flush,
  input  logic    disp_valid0,
  input  uop_t    disp_uop0,
  input  logic    disp_valid1,
  input  uop_t    disp_uop1,
  alloc_if.src    alloc,
  wakeup_if.snoop wake
);

  localparam logic [`PREG_COUNT-1:0] SB_INIT = `PREG_COUNT'({`PREG_RDY{1'b1}});

  logic [`PREG_COUNT-1:0] sb;      // One ready bit per physical register
  logic [`PREG_COUNT-1:0] sb_nxt;
  logic                   acc0;
  logic                   acc1;

  // Scoreboard or a writeback in this very cycle
  function automatic logic src_ready(input logic [`TAG_W-1:0] tag);
    return sb[tag] || wake_hit(tag, wake.wb_v0, wake.wb_tag0, wake.wb_v1, wake.wb_tag1);
  endfunction

  function automatic iq_entry_t mark(input uop_t u);
    iq_entry_t e;
    e.uop  = u;
    e.rdy1 = src_ready(u.src1);
    e.rdy2 = (u.op == ADDI) || src_ready(u.src2.r.tag);
    return e;
  endfunction

  // Lanes fill free slots in order
  assign acc0 = disp_valid0 && !flush && (alloc.free >= 1);
  assign acc1 = disp_valid1 && !flush &&
                ((alloc.free >= 2) || (alloc.free == 1 && !disp_valid0));

  assign alloc.we0    = acc0;
  assign alloc.we1    = acc1;
  assign alloc.entry0 = mark(disp_uop0);
  assign alloc.entry1 = mark(disp_uop1);

  always_comb begin
    sb_nxt = sb;
    if (wake.wb_v0)
      sb_nxt[wake.wb_tag0] = 1'b1;
    if (wake.wb_v1)
      sb_nxt[wake.wb_tag1] = 1'b1;
    if (acc0)
      sb_nxt[disp_uop0.dest] = 1'b0;   // Pending until its writeback
    if (acc1)
      sb_nxt[disp_uop1.dest] = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      sb <= SB_INIT;
    else
      sb <= sb_nxt;
  end

  // Source must respect free, a dropped lane is lost for good
  a_no_drop: assert property (@(posedge clk) disable iff (!rst_n || flush)
    (disp_valid0 |-> acc0) and (disp_valid1 |-> acc1));

  a_dest_unique: assert property (@(posedge clk) disable iff (!rst_n)
    (acc0 && acc1) |-> (disp_uop0.dest != disp_uop1.dest));

endmodule

//--- src/exec_unit.sv
`timescale 1ns/100ps

`include "iq_macros.svh"

module exec_unit import iq_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  issue_if.dst               iss,
  wakeup_if.drv              wake,
  output logic               wb_valid0,
  output logic               wb_valid1,
  output logic [`TAG_W-1:0]  wb_tag0,
  output logic [`TAG_W-1:0]  wb_tag1,
  output logic [`DATA_W-1:0] wb_value0,
  output logic [`DATA_W-1:0] wb_value1
);

  logic [`DATA_W-1:0]     rf    [`PREG_COUNT];
  logic [`DATA_W-1:0]     rf_wd [`PREG_COUNT];
  logic [`PREG_COUNT-1:0] rf_we;

  function automatic logic [`DATA_W-1:0] alu(input uop_t u);
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    a = rf[u.src1];
    b = (u.op == ADDI) ? `DATA_W'(u.src2.imm) : rf[u.src2.r.tag];  // Zero-extended
    case (u.op)
      SUB:     return a - b;
      XOR:     return a ^ b;
      default: return a + b;   // ADD and ADDI
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid0 <= 1'b0;
      wb_valid1 <= 1'b0;
    end else begin
      wb_valid0 <= iss.v0;
      wb_valid1 <= iss.v1;
    end
  end

  always_ff @(posedge clk) begin
    wb_tag0   <= iss.uop0.dest;
    wb_tag1   <= iss.uop1.dest;
    wb_value0 <= alu(iss.uop0);
    wb_value1 <= alu(iss.uop1);
  end

  assign wake.wb_v0   = wb_valid0;
  assign wake.wb_tag0 = wb_tag0;
  assign wake.wb_v1   = wb_valid1;
  assign wake.wb_tag1 = wb_tag1;

  always_comb begin
    for (int g = 0; g < `PREG_COUNT; g++) begin
      rf_we[g] = (wb_valid0 && wb_tag0 == `TAG_W'(g)) ||
                 (wb_valid1 && wb_tag1 == `TAG_W'(g));
      rf_wd[g] = (wb_valid0 && wb_tag0 == `TAG_W'(g)) ? wb_value0 : wb_value1;
    end
  end

  // Low registers come up holding their index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int g = 0; g < `PREG_RDY; g++)
        rf[g] <= `DATA_W'(g);
    end else begin
      for (int g = 0; g < `PREG_COUNT; g++) begin
        if (rf_we[g])
          rf[g] <= rf_wd[g];
      end
    end
  end

  a_wb_tags_differ: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid0 && wb_valid1) |-> (wb_tag0 != wb_tag1));

endmodule

//--- src/iq_interfaces.sv
`timescale 1ns/100ps

`include "iq_macros.svh"

// Dispatch to queue, two write lanes plus the free count back
interface alloc_if import iq_pkg::*; ();
  logic                 we0;
  logic                 we1;
  iq_entry_t            entry0;
  iq_entry_t            entry1;
  logic [`IQ_CNT_W-1:0] free;

  modport src (output we0, we1, entry0, entry1, input free);
  modport dst (input we0, we1, entry0, entry1, output free);
endinterface

// Registered issue slots, queue to execute
interface issue_if import iq_pkg::*; ();
  logic v0;
  logic v1;
  uop_t uop0;
  uop_t uop1;

  modport src (output v0, v1, uop0, uop1);
  modport dst (input v0, v1, uop0, uop1);
endinterface

interface wakeup_if ();
  logic              wb_v0;
  logic [`TAG_W-1:0] wb_tag0;
  logic              wb_v1;
  logic [`TAG_W-1:0] wb_tag1;

  modport drv   (output wb_v0, wb_tag0, wb_v1, wb_tag1);
  modport snoop (input wb_v0, wb_tag0, wb_v1, wb_tag1);
endinterface

//--- src/iq_macros.svh
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

`define IQ_ENTRIES 8
`define IQ_CNT_W   4   // Holds 0 to IQ_ENTRIES

`define PREG_COUNT 32
`define TAG_W      5
`define DATA_W     16

// Tags below this hold their own index out of reset and start ready
`define PREG_RDY   8

`endif

//--- src/iq_pkg.sv
`include "iq_macros.svh"

package iq_pkg;

  typedef enum logic [1:0] {
    ADD,
    SUB,
    XOR,
    ADDI
  } alu_op_e;

  // Second operand field, register tag or 8-bit immediate
  typedef union packed {
    struct packed {
      logic [7-`TAG_W:0] pad;
      logic [`TAG_W-1:0] tag;
    } r;
    logic [7:0] imm;    // ADDI only
  } src2_u;

  typedef struct packed {
    alu_op_e           op;
    logic [`TAG_W-1:0] dest;
    logic [`TAG_W-1:0] src1;
    src2_u             src2;
  } uop_t;

  typedef struct packed {
    uop_t uop;
    logic rdy1;
    logic rdy2;
  } iq_entry_t;

  // Tag match against either writeback lane
  function automatic logic wake_hit(input logic [`TAG_W-1:0] tag,
                                    input logic              v0,
                                    input logic [`TAG_W-1:0] t0,
                                    input logic              v1,
                                    input logic [`TAG_W-1:0] t1);
    return (v0 && t0 == tag) || (v1 && t1 == tag);
  endfunction

endpackage

//--- src/issue_queue.sv
`timescale 1ns/100ps

`include "iq_macros.svh"

module issue_queue import iq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  alloc_if.dst                 alloc,
  issue_if.src                 iss,
  wakeup_if.snoop              wake,
  output logic [`IQ_CNT_W-1:0] count,
  output logic [`IQ_CNT_W-1:0] free
);

  localparam int IDX_W = $clog2(`IQ_ENTRIES);

  iq_entry_t              slot [`IQ_ENTRIES];
  logic [`IQ_ENTRIES-1:0] valid;
  logic [`IQ_ENTRIES-1:0] ready;
  logic [`IQ_ENTRIES-1:0] alloc_mask;
  logic [`IQ_ENTRIES-1:0] sel_mask;
  logic [IDX_W-1:0]       fr0;
  logic [IDX_W-1:0]       fr1;
  logic                   fr0_ok;
  logic                   fr1_ok;
  logic [IDX_W-1:0]       a1_idx;
  logic                   a1_ok;
  logic [IDX_W-1:0]       sel0;
  logic [IDX_W-1:0]       sel1;
  logic                   sel0_ok;
  logic                   sel1_ok;

  // Lowest and second lowest set bit, packed as {ok1, idx1, ok0, idx0}
  function automatic logic [2*IDX_W+1:0] pick_two(input logic [`IQ_ENTRIES-1:0] m);
    logic [IDX_W-1:0] p0;
    logic [IDX_W-1:0] p1;
    logic             f0;
    logic             f1;
    p0 = '0;
    p1 = '0;
    f0 = 1'b0;
    f1 = 1'b0;
    for (int i = 0; i < `IQ_ENTRIES; i++) begin
      if (m[i] && !f0) begin
        p0 = IDX_W'(i);
        f0 = 1'b1;
      end else if (m[i] && !f1) begin
        p1 = IDX_W'(i);
        f1 = 1'b1;
      end
    end
    return {f1, p1, f0, p0};
  endfunction

  always_comb begin
    for (int i = 0; i < `IQ_ENTRIES; i++)
      ready[i] = valid[i] && slot[i].rdy1 && slot[i].rdy2;
  end

  assign {fr1_ok, fr1, fr0_ok, fr0}     = pick_two(~valid);
  assign {sel1_ok, sel1, sel0_ok, sel0} = pick_two(ready);

  // Lane 1 takes the first free slot when lane 0 is idle
  assign a1_idx = alloc.we0 ? fr1 : fr0;
  assign a1_ok  = alloc.we1 && (alloc.we0 ? fr1_ok : fr0_ok);

  always_comb begin
    alloc_mask = '0;
    sel_mask   = '0;
    if (alloc.we0 && fr0_ok)
      alloc_mask[fr0] = 1'b1;
    if (a1_ok)
      alloc_mask[a1_idx] = 1'b1;
    if (sel0_ok)
      sel_mask[sel0] = 1'b1;
    if (sel1_ok)
      sel_mask[sel1] = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      valid <= '0;
    else if (flush)
      valid <= '0;
    else
      valid <= (valid & ~sel_mask) | alloc_mask;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `IQ_ENTRIES; i++) begin
      if (alloc.we0 && fr0_ok && fr0 == IDX_W'(i)) begin
        slot[i] <= alloc.entry0;
      end else if (a1_ok && a1_idx == IDX_W'(i)) begin
        slot[i] <= alloc.entry1;
      end else begin
        if (wake_hit(slot[i].uop.src1, wake.wb_v0, wake.wb_tag0, wake.wb_v1, wake.wb_tag1))
          slot[i].rdy1 <= 1'b1;
        if (wake_hit(slot[i].uop.src2.r.tag, wake.wb_v0, wake.wb_tag0,
                     wake.wb_v1, wake.wb_tag1))
          slot[i].rdy2 <= 1'b1;   // Harmless for ADDI, already set
      end
    end
  end

  // Picks made during a flush are dropped with the rest
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss.v0 <= 1'b0;
      iss.v1 <= 1'b0;
    end else begin
      iss.v0 <= sel0_ok && !flush;
      iss.v1 <= sel1_ok && !flush;
    end
  end

  always_ff @(posedge clk) begin
    iss.uop0 <= slot[sel0].uop;
    iss.uop1 <= slot[sel1].uop;
  end

  always_comb begin
    count = '0;
    free  = '0;
    for (int i = 0; i < `IQ_ENTRIES; i++) begin
      count = count + `IQ_CNT_W'(valid[i]);
      free  = free + `IQ_CNT_W'(!valid[i]);
    end
  end

  assign alloc.free = free;

  // Every lane that dispatch accepts finds a free slot
  a_alloc_fits: assert property (@(posedge clk) disable iff (!rst_n)
    (alloc.we0 |-> fr0_ok) and (alloc.we1 |-> a1_ok));

endmodule

//--- src/ooo_issue_top.sv
`timescale 1ns/100ps

`include "iq_macros.svh"

module ooo_issue_top import iq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 disp_valid0,
  input  uop_t                 disp_uop0,
  input  logic                 disp_valid1,
  input  uop_t                 disp_uop1,
  output logic [`IQ_CNT_W-1:0] count,
  output logic [`IQ_CNT_W-1:0] free,
  output logic                 wb_valid0,
  output logic [`TAG_W-1:0]    wb_tag0,
  output logic [`DATA_W-1:0]   wb_value0,
  output logic                 wb_valid1,
  output logic [`TAG_W-1:0]    wb_tag1,
  output logic [`DATA_W-1:0]   wb_value1
);

  alloc_if  i_alloc ();
  issue_if  i_issue ();
  wakeup_if i_wake ();

  dispatch_stage i_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .disp_valid0 (disp_valid0),
    .disp_uop0   (disp_uop0),
    .disp_valid1 (disp_valid1),
    .disp_uop1   (disp_uop1),
    .alloc       (i_alloc.src),
    .wake        (i_wake.snoop)
  );

  issue_queue i_queue (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (flush),
    .alloc (i_alloc.dst),
    .iss   (i_issue.src),
    .wake  (i_wake.snoop),
    .count (count),
    .free  (free)
  );

  exec_unit i_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .iss       (i_issue.dst),
    .wake      (i_wake.drv),
    .wb_valid0 (wb_valid0),
    .wb_valid1 (wb_valid1),
    .wb_tag0   (wb_tag0),
    .wb_tag1   (wb_tag1),
    .wb_value0 (wb_value0),
    .wb_value1 (wb_value1)
  );

endmodule

//--- verification/tb_ooo_issue.sv
`timescale 1ns/100ps

`include "iq_macros.svh"

module tb_ooo_issue import iq_pkg::*; ();

  localparam int CYC_LIMIT = 400;
  localparam int M_INDEP   = 0;   // Sources from tags 0 to 7 only
  localparam int M_CHAIN   = 1;
  localparam int M_IMM     = 2;
  localparam int M_SERIAL  = 3;   // Each op reads the previous result

  logic                 clk;
  logic                 rst_n;
  logic                 flush;
  logic                 disp_valid0;
  logic                 disp_valid1;
  uop_t                 disp_uop0;
  uop_t                 disp_uop1;
  logic [`IQ_CNT_W-1:0] count;
  logic [`IQ_CNT_W-1:0] free;
  logic                 wb_valid0;
  logic                 wb_valid1;
  logic [`TAG_W-1:0]    wb_tag0;
  logic [`TAG_W-1:0]    wb_tag1;
  logic [`DATA_W-1:0]   wb_value0;
  logic [`DATA_W-1:0]   wb_value1;

  logic [31:0]          lfsr;
  logic [`DATA_W-1:0]   mval [`PREG_COUNT];  // Model register values
  bit                   in_flight [`PREG_COUNT];
  logic [`TAG_W-1:0]    known [$];           // Tags a source may name
  logic [7:0]           imm_byte;
  bit                   imm_phase;
  int                   next_dest;
  int                   errors = 0;
  int                   checks = 0;
  int                   tests_run = 0;
  int                   tests_ok = 0;
  int                   max_count = 0;
  int                   hold = 3;
  int                   cnt1 = 0;
  int                   cnt2 = 0;
  int                   lanes1 = 0;
  int                   lanes2 = 0;

  ooo_issue_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .disp_valid0 (disp_valid0),
    .disp_uop0   (disp_uop0),
    .disp_valid1 (disp_valid1),
    .disp_uop1   (disp_uop1),
    .count       (count),
    .free        (free),
    .wb_valid0   (wb_valid0),
    .wb_tag0     (wb_tag0),
    .wb_value0   (wb_value0),
    .wb_valid1   (wb_valid1),
    .wb_tag1     (wb_tag1),
    .wb_value1   (wb_value1)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  function automatic logic [`TAG_W-1:0] pick_src(input bit low_only);
    int n;
    n = low_only ? `PREG_RDY : known.size();
    return known[rand_bits(5) % n];
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < `PREG_COUNT; i++)
      n += int'(in_flight[i]);
    return n;
  endfunction

  // Builds one micro-op and its expected result
  task automatic make_uop(input int mode, output uop_t u);
    logic [`TAG_W-1:0]  tag2;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    u.op   = alu_op_e'(2'(rand_bits(2)));
    u.dest = `TAG_W'(next_dest);
    u.src1 = (mode == M_SERIAL) ? known[known.size() - 1] : pick_src(mode == M_INDEP);
    tag2   = pick_src(mode == M_INDEP);
    u.src2.imm = {3'(rand_bits(3)), tag2};
    if (mode == M_IMM) begin
      if (!imm_phase) begin
        u.op = ADDI;
        imm_byte = u.src2.imm;
      end else begin
        u.op = alu_op_e'(2'(rand_bits(2) % 3));  // Register form, same byte
        u.src2.imm = imm_byte;
      end
      imm_phase = !imm_phase;
    end
    a = mval[u.src1];
    b = (u.op == ADDI) ? `DATA_W'(u.src2.imm) : mval[u.src2.r.tag];
    case (u.op)
      SUB:     mval[u.dest] = a - b;
      XOR:     mval[u.dest] = a ^ b;
      default: mval[u.dest] = a + b;
    endcase
    in_flight[u.dest] = 1'b1;
    known.push_back(u.dest);
    next_dest++;
  endtask

  task automatic check_wb(input logic v, input logic [`TAG_W-1:0] tag,
                          input logic [`DATA_W-1:0] value, input int lane);
    if (v) begin
      checks++;
      assert (in_flight[tag]) else begin
        $display("Writeback at %0t on lane %0d names tag %0d, which is not in flight",
                 $time, lane, tag);
        errors++;
      end
      if (in_flight[tag]) begin
        assert (value == mval[tag]) else begin
          $display("Fail %0t wb_value%0d (tag %0d): got %h, expected %h",
                   $time, lane, tag, value, mval[tag]);
          errors++;
        end
        in_flight[tag] = 1'b0;
      end
    end
  endtask

  always @(negedge clk) begin : wb_monitor
    int nwb;
    nwb = int'(wb_valid0) + int'(wb_valid1);  // Picks made two edges back
    if (rst_n) begin
      check_wb(wb_valid0, wb_tag0, wb_value0, 0);
      check_wb(wb_valid1, wb_tag1, wb_value1, 1);
      checks++;
      assert (int'(count) + int'(free) == `IQ_ENTRIES) else begin
        $display("Fail %0t count+free: got %0d, expected %0d",
                 $time, int'(count) + int'(free), `IQ_ENTRIES);
        errors++;
      end
      if (hold == 0) begin
        checks++;
        assert (cnt1 == cnt2 + lanes2 - nwb) else begin
          $display("Fail %0t count (previous cycle): got %0d, expected %0d",
                   $time, cnt1, cnt2 + lanes2 - nwb);
          errors++;
        end
      end
      if (int'(count) > max_count)
        max_count = int'(count);
    end
    cnt2   = cnt1;
    cnt1   = int'(count);
    lanes2 = lanes1;
    lanes1 = int'(disp_valid0) + int'(disp_valid1);
    if (!rst_n || flush)
      hold = 3;
    else if (hold > 0)
      hold--;
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_n       <= 1'b0;
    flush       <= 1'b0;
    disp_valid0 <= 1'b0;
    disp_valid1 <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    known.delete();
    for (int i = 0; i < `PREG_COUNT; i++) begin
      mval[i]      = (i < `PREG_RDY) ? `DATA_W'(i) : '0;
      in_flight[i] = 1'b0;
      if (i < `PREG_RDY)
        known.push_back(`TAG_W'(i));
    end
    next_dest = `PREG_RDY;
    imm_phase = 1'b0;
    @(negedge clk);
    checks += 3;
    assert (count == '0) else begin
      $display("Fail %0t count: got %0d, expected 0", $time, count);
      errors++;
    end
    assert (free == `IQ_CNT_W'(`IQ_ENTRIES)) else begin
      $display("Fail %0t free: got %0d, expected %0d", $time, free, `IQ_ENTRIES);
      errors++;
    end
    assert (!wb_valid0 && !wb_valid1) else begin
      $display("A writeback strobe is set right after reset");
      errors++;
    end
  endtask

  // Never asks for more lanes than free can take after pending ones land
  task automatic dispatch_ops(input int mode, input int n_ops);
    int   sent;
    int   idle;
    int   want;
    int   room;
    uop_t u0;
    uop_t u1;
    bit   lone1;
    sent = 0;
    idle = 0;
    while (sent < n_ops && idle < CYC_LIMIT) begin
      @(negedge clk);
      room = int'(free) - int'(disp_valid0) - int'(disp_valid1);
      want = (mode == M_SERIAL) ? 2 : rand_bits(2) % 3;
      if (want > room)
        want = room;
      if (want > n_ops - sent)
        want = n_ops - sent;
      if (want < 0)
        want = 0;
      lone1 = (rand_bits(1) != 0);
      @(posedge clk);
      u0 = '0;
      u1 = '0;
      if (want >= 1)
        make_uop(mode, u0);
      if (want == 2)
        make_uop(mode, u1);
      disp_valid0 <= (want == 2) || (want == 1 && !lone1);
      disp_uop0   <= u0;
      disp_valid1 <= (want == 2) || (want == 1 && lone1);
      disp_uop1   <= (want == 2) ? u1 : u0;
      sent += want;
      idle = (want == 0) ? idle + 1 : 0;
    end
    @(posedge clk);
    disp_valid0 <= 1'b0;
    disp_valid1 <= 1'b0;
    if (sent < n_ops) begin
      $display("Timeout: dispatch stalled after %0d of %0d micro-ops", sent, n_ops);
      errors++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending_count() != 0 && n < CYC_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (pending_count() != 0) begin
      $display("Timeout: %0d tags were never written back", pending_count());
      errors++;
    end
  endtask

  task automatic flush_queue();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    checks++;
    assert (count == '0) else begin
      $display("Fail %0t count after flush: got %0d, expected 0", $time, count);
      errors++;
    end
    repeat (2) @(posedge clk);   // Issue and writeback stages drain
    for (int i = 0; i < `PREG_COUNT; i++)
      in_flight[i] = 1'b0;
    repeat (12) @(posedge clk);  // Any writeback now is a stray one
  endtask

  task automatic run_test(input int num, input string name, input int mode,
                          input int n_ops, input bit do_flush);
    int errs_before;
    errs_before = errors;
    apply_reset();
    max_count = 0;
    if (n_ops > 0)
      dispatch_ops(mode, n_ops);
    if (do_flush)
      flush_queue();
    else
      wait_drain();
    if (mode == M_SERIAL) begin
      checks++;
      assert (max_count == `IQ_ENTRIES) else begin
        $display("The queue never filled up, peak count was %0d", max_count);
        errors++;
      end
    end
    tests_run++;
    if (errors == errs_before)
      tests_ok++;
    $display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    rst_n       = 1'b0;
    flush       = 1'b0;
    disp_valid0 = 1'b0;
    disp_valid1 = 1'b0;
    disp_uop0   = '0;
    disp_uop1   = '0;
    lfsr        = 32'd88018;
    run_test(1, "reset state", M_INDEP, 0, 1'b0);
    run_test(2, "independent ops", M_INDEP, 24, 1'b0);
    run_test(3, "dependency chains", M_CHAIN, 24, 1'b0);
    run_test(4, "immediate and tag views", M_IMM, 24, 1'b0);
    run_test(5, "dual dispatch fill", M_SERIAL, 24, 1'b0);
    run_test(6, "flush", M_CHAIN, 16, 1'b1);
    $display("%0d of %0d tests ok, %0d checks, %0d errors", tests_ok, tests_run, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
